// ==== build.f ====
+incdir+include
design/marble_lb_pkg.sv
design/lb_if.sv
design/lb_dpram.sv
design/status_bank.sv
design/ctrl_regs.sv
design/led_pwm.sv
design/rx_counter.sv
design/lb_read_mux.sv
design/lb_marble_slave.sv
tb/tb_lb_marble_slave.sv

// ==== Makefile ====
# Verilator build and run of the local bus register slave testbench

VERILATOR ?= verilator
TOP       ?= tb_lb_marble_slave
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_lb_marble_slave.sv ====
// Testbench for the local bus register slave: bus tasks, reference model, checks and summary
`timescale 1ns/100ps
`default_nettype none

`include "marble_cfg.svh"

module tb_lb_marble_slave;
	import marble_lb_pkg::*;

	localparam int WATCHDOG_NS = 5_000_000;

	logic         clk = 1'b0;
	logic         rst_n;
	lb_addr_t     addr;
	logic         control_strobe;
	logic         control_rd;
	lb_word_t     data_out;
	lb_word_t     data_in;
	logic         xdomain_fault;
	logic         tx_mac_done;
	logic [1:0]   rx_mac_buf_status;
	logic         rx_category_s;
	logic [3:0]   rx_category;
	logic [1:0]   led_user_mode;
	logic         led1;
	logic         led2;
	logic         cfg_d02;
	logic         mmc_int;
	logic         allow_mmc_eth_config;
	logic         zest_pwr_en;
	logic [3:0]   ext_config;
	logic [31:0]  cycle_count = '0;
	logic [31:0]  lcg_state;
	int           checks;
	int           errors;
	int           test_errors;
	int           tests_failed;
	int           test_num;
	string        test_name;

	// Reference model
	lb_word_t     mirror_model [0:31];
	logic         mirror_written [0:31];
	logic [1:0]   mode_model;
	logic [7:0]   cfg_model;
	rx_count_t    rx_model [0:15];

	lb_marble_slave dut_i (
		.clk                  (clk),
		.rst_n                (rst_n),
		.addr                 (addr),
		.control_strobe       (control_strobe),
		.control_rd           (control_rd),
		.data_out             (data_out),
		.data_in              (data_in),
		.xdomain_fault        (xdomain_fault),
		.tx_mac_done          (tx_mac_done),
		.rx_mac_buf_status    (rx_mac_buf_status),
		.rx_category_s        (rx_category_s),
		.rx_category          (rx_category),
		.led_user_mode        (led_user_mode),
		.led1                 (led1),
		.led2                 (led2),
		.cfg_d02              (cfg_d02),
		.mmc_int              (mmc_int),
		.allow_mmc_eth_config (allow_mmc_eth_config),
		.zest_pwr_en          (zest_pwr_en),
		.ext_config           (ext_config)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 32'd1;
	end

	// --------------------
	// Helpers
	// --------------------
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic lb_addr_t status_addr(input logic [3:0] off);
		return {`LB_PAGE_STATUS, 12'h000, off};
	endfunction

	function automatic lb_addr_t local_addr(input logic [4:0] off);
		return {`LB_PAGE_LOCAL, 11'h000, off};
	endfunction

	function automatic lb_addr_t rxcnt_addr(input logic [3:0] cat);
		return {`LB_PAGE_RXCNT, 8'h00, cat};
	endfunction

	// One clock, landing just after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			$display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_range(input string name, input logic [31:0] got,
			input logic [31:0] lo, input logic [31:0] hi);
		checks++;
		assert (got >= lo && got <= hi)
		else begin
			$display("FAIL t=%0t %s got=%0d expected=%0d..%0d", $time, name, got, lo, hi);
			errors++;
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_num++;
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			$display("test %0d %s: ok", test_num, test_name);
		end else begin
			$display("test %0d %s: %0d errors", test_num, test_name, test_errors);
			tests_failed++;
		end
	endtask

	// --------------------
	// Bus tasks
	// --------------------
	task automatic lb_write(input lb_addr_t a, input lb_word_t d);
		addr = a;
		data_out = d;
		control_rd = 1'b0;
		control_strobe = 1'b1;
		step();
		control_strobe = 1'b0;
	endtask

	// Data lands two edges after the strobe is driven
	task automatic lb_read(input lb_addr_t a, output lb_word_t d);
		addr = a;
		control_rd = 1'b1;
		control_strobe = 1'b1;
		step();
		control_strobe = 1'b0;
		control_rd = 1'b0;
		step();
		d = data_in;
	endtask

	task automatic read_pair(input lb_addr_t a, input lb_addr_t b,
			output lb_word_t da, output lb_word_t db);
		addr = a;
		control_rd = 1'b1;
		control_strobe = 1'b1;
		step();
		addr = b;
		step();
		da = data_in;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		step();
		db = data_in;
	endtask

	// Local write plus the model update it implies
	task automatic write_local(input logic [4:0] off, input lb_word_t d);
		lb_write(local_addr(off), d);
		mirror_model[off] = d;
		mirror_written[off] = 1'b1;
		case (off)
			5'd1: mode_model = d[1:0];
			5'd8: cfg_model = d[7:0];
			default: ;
		endcase
	endtask

	task automatic check_ctrl_outputs();
		check_value("led_user_mode", 32'(led_user_mode), 32'(mode_model));
		check_value("cfg_d02", 32'(cfg_d02), 32'(cfg_model[0]));
		check_value("mmc_int", 32'(mmc_int), 32'(cfg_model[1]));
		check_value("allow_mmc_eth_config", 32'(allow_mmc_eth_config), 32'(cfg_model[2]));
		check_value("zest_pwr_en", 32'(zest_pwr_en), 32'(cfg_model[3]));
		check_value("ext_config", 32'(ext_config), 32'(cfg_model[7:4]));
	endtask

	task automatic wait_led1_rise(input int limit);
		int   n;
		logic prev;
		n = 0;
		prev = led1;
		step();
		while (!(led1 && !prev) && n < limit) begin
			prev = led1;
			step();
			n++;
		end
		if (!(led1 && !prev)) begin
			$display("Timeout: led1 did not turn on within %0d cycles", limit);
			errors++;
			test_errors++;
		end
	endtask

	// --------------------
	// Tests
	// --------------------
	task automatic test_reset_and_id();
		lb_word_t d0;
		lb_word_t d1;
		lb_addr_t unmapped;
		logic [31:0] r;
		begin_test("reset_and_id");
		check_ctrl_outputs();
		check_value("led1", 32'(led1), 32'd0);
		check_value("led2", 32'(led2), 32'd0);
		check_value("data_in", data_in, 32'd0);
		r = next_rand();
		// Pages from 0x80 up are claimed by nobody
		unmapped = {1'b1, r[22:16], r[15:0]};
		lb_read(status_addr(4'd0), d0);
		check_value("status[0]", d0, "Hell");
		read_pair(status_addr(4'd1), status_addr(4'd2), d0, d1);
		check_value("status[1]", d0, "o wo");
		check_value("status[2]", d1, "rld!");
		read_pair(status_addr(4'd3), unmapped, d0, d1);
		check_value("status[3]", d0, "(::)");
		check_value("unmapped read", d1, `LB_DEFAULT_DATA);
		read_pair(unmapped, status_addr(4'd0), d0, d1);
		check_value("unmapped read", d0, `LB_DEFAULT_DATA);
		check_value("status[0]", d1, "Hell");
		end_test();
	endtask

	task automatic test_control_writes();
		logic [31:0] r;
		logic [4:0]  off;
		lb_word_t    d;
		int          i;
		begin_test("control_writes");
		for (i = 0; i < 24; i++) begin
			r = next_rand();
			case (r[1:0])
				2'd0: off = 5'd1;
				2'd1: off = 5'd2;
				2'd2: off = 5'd3;
				default: off = 5'd8;
			endcase
			// Now and then an offset that only lands in the mirror
			if (r[2])
				off = r[7:3];
			write_local(off, next_rand());
			check_ctrl_outputs();
		end
		for (i = 0; i < 32; i++) begin
			if (mirror_written[i[4:0]]) begin
				lb_read(local_addr(i[4:0]), d);
				check_value($sformatf("mirror[%0d]", i), d, mirror_model[i[4:0]]);
			end
		end
		end_test();
	endtask

	task automatic test_led_pwm();
		logic [31:0] r;
		logic [7:0]  duty1;
		logic [7:0]  duty2;
		logic [31:0] cnt1;
		logic [31:0] cnt2;
		int          trial;
		int          i;
		begin_test("led_pwm");
		for (trial = 0; trial < 2; trial++) begin
			r = next_rand();
			duty1 = (r[7:0] == 8'd0) ? 8'd1 : r[7:0];
			duty2 = r[15:8];
			write_local(5'd2, {24'd0, duty1});
			write_local(5'd3, {24'd0, duty2});
			wait_led1_rise(2100);
			cnt1 = '0;
			cnt2 = '0;
			for (i = 0; i < 1024; i++) begin
				if (led1)
					cnt1 = cnt1 + 32'd1;
				if (led2)
					cnt2 = cnt2 + 32'd1;
				step();
			end
			check_value("led1 high cycles", cnt1, 32'(duty1) * 32'd4);
			check_value("led2 high cycles", cnt2, 32'(duty2) * 32'd4);
		end
		end_test();
	endtask

	task automatic test_status_counters();
		logic [31:0] r;
		logic [31:0] n;
		logic [31:0] gap;
		logic [31:0] up0;
		logic [31:0] up1;
		logic [31:0] c0;
		logic [31:0] elapsed;
		logic        tx_lvl;
		logic [1:0]  rx_lvl;
		lb_word_t    d;
		int          k;
		begin_test("status_counters");
		n = 32'd1 + 32'(next_rand() & 32'd31);
		for (k = 0; k < int'(n); k++) begin
			xdomain_fault = 1'b1;
			step();
			xdomain_fault = 1'b0;
			gap = next_rand() & 32'd3;
			repeat (gap) step();
		end
		step();
		lb_read(status_addr(4'd4), d);
		check_value("fault count", d, {16'd0, n[15:0]});
		// Uptime advances once per 1024 cycles, over at least two periods here
		lb_read(status_addr(4'd5), up0);
		c0 = cycle_count;
		gap = 32'd2200 + (next_rand() & 32'd2047);
		repeat (gap) step();
		lb_read(status_addr(4'd5), up1);
		elapsed = cycle_count - c0;
		check_range("uptime delta", up1 - up0, (elapsed >> 10) - 32'd1,
			(elapsed >> 10) + 32'd1);
		// Each MAC level takes every value once, in a random order
		r = next_rand();
		for (k = 0; k < 4; k++) begin
			tx_lvl = k[0] ^ r[2];
			rx_lvl = k[1:0] ^ r[1:0];
			tx_mac_done = tx_lvl;
			rx_mac_buf_status = rx_lvl;
			step();
			step();
			lb_read(status_addr(4'd6), d);
			check_value("tx_mac_done status", d, 32'(tx_lvl));
			lb_read(status_addr(4'd7), d);
			check_value("rx_mac_buf_status status", d, 32'(rx_lvl));
		end
		end_test();
	endtask

	task automatic test_rx_counters();
		logic [31:0] r;
		logic [31:0] gap;
		logic [3:0]  cat;
		lb_word_t    d;
		int          k;
		begin_test("rx_counters");
		for (k = 0; k < 60; k++) begin
			r = next_rand();
			cat = r[3:0];
			rx_category = cat;
			rx_category_s = 1'b1;
			step();
			rx_category_s = 1'b0;
			rx_model[cat] = rx_model[cat] + rx_count_t'(1);
			// At least one idle cycle between pulses
			gap = 32'd1 + 32'(r[5:4]);
			repeat (gap) step();
		end
		repeat (4) step();
		for (k = 0; k < 16; k++) begin
			lb_read(rxcnt_addr(k[3:0]), d);
			check_value($sformatf("rx count[%0d]", k), d, 32'(rx_model[k[3:0]]));
		end
		end_test();
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		int i;
		rst_n = 1'b0;
		addr = '0;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		data_out = '0;
		xdomain_fault = 1'b0;
		tx_mac_done = 1'b0;
		rx_mac_buf_status = 2'b00;
		rx_category_s = 1'b0;
		rx_category = 4'd0;
		lcg_state = 32'h9fe2_f491;
		checks = 0;
		errors = 0;
		tests_failed = 0;
		test_num = 0;
		mode_model = 2'b00;
		cfg_model = `MISC_CONFIG_DEFAULT;
		for (i = 0; i < 32; i++)
			mirror_written[i[4:0]] = 1'b0;
		for (i = 0; i < 16; i++)
			rx_model[i[3:0]] = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset_and_id();
		test_control_writes();
		test_led_pwm();
		test_status_counters();
		test_rx_counters();
		$display("tests=%0d tests_with_errors=%0d checks=%0d errors=%0d",
			test_num, tests_failed, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Simulation time limit reached before all tests completed");
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/lb_marble_slave.sv ====
// Local bus register slave top level: bus interface, register peers and read mux
`timescale 1ns/100ps
`default_nettype none

`include "marble_cfg.svh"

module lb_marble_slave (
	input  wire                          clk,
	input  wire                          rst_n,
	// Local bus
	input  wire marble_lb_pkg::lb_addr_t addr,
	input  wire                          control_strobe,
	input  wire                          control_rd,
	input  wire marble_lb_pkg::lb_word_t data_out,
	output marble_lb_pkg::lb_word_t      data_in,
	// Status and statistics sources
	input  wire                          xdomain_fault,
	input  wire                          tx_mac_done,
	input  wire [1:0]                    rx_mac_buf_status,
	input  wire                          rx_category_s,
	input  wire [`RXCNT_AW-1:0]          rx_category,
	// Board outputs
	output logic [1:0]                   led_user_mode,
	output logic                         led1,
	output logic                         led2,
	output logic                         cfg_d02,
	output logic                         mmc_int,
	output logic                         allow_mmc_eth_config,
	output logic                         zest_pwr_en,
	output logic [3:0]                   ext_config
);
	import marble_lb_pkg::*;

	lb_word_t     status_data;
	rx_count_t    rxcnt_data;
	lb_word_t     mirror_data;
	logic         local_wr;
	duty_t        led1_duty;
	duty_t        led2_duty;
	misc_config_t misc_config;
	logic         uptime_tick;

	// --------------------
	// Bus into the interface
	// --------------------
	lb_if bus_if ();

	assign bus_if.addr   = addr;
	assign bus_if.strobe = control_strobe;
	assign bus_if.rd     = control_rd;
	assign bus_if.wdata  = data_out;

	status_bank status_i (
		.clk               (clk),
		.rst_n             (rst_n),
		.bus               (bus_if),
		.xdomain_fault     (xdomain_fault),
		.tx_mac_done       (tx_mac_done),
		.rx_mac_buf_status (rx_mac_buf_status),
		.uptime_tick       (uptime_tick),
		.status_data       (status_data)
	);

	ctrl_regs ctrl_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.bus           (bus_if),
		.local_wr      (local_wr),
		.led_user_mode (led_user_mode),
		.led1_duty     (led1_duty),
		.led2_duty     (led2_duty),
		.misc_config   (misc_config)
	);

	led_pwm led_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.led1_duty   (led1_duty),
		.led2_duty   (led2_duty),
		.led1        (led1),
		.led2        (led2),
		.uptime_tick (uptime_tick)
	);

	rx_counter rxcnt_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.bus           (bus_if),
		.rx_category_s (rx_category_s),
		.rx_category   (rx_category),
		.rxcnt_data    (rxcnt_data)
	);

	// Every local write is kept for readback on the same page
	lb_dpram #(.payload_t(lb_word_t), .AW(`MIRROR_AW)) mirror_i (
		.clk   (clk),
		.we    (local_wr),
		.waddr (addr[`MIRROR_AW-1:0]),
		.wdata (data_out),
		.raddr (addr[`MIRROR_AW-1:0]),
		.rdata (mirror_data)
	);

	lb_read_mux read_mux_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.bus         (bus_if),
		.status_data (status_data),
		.rxcnt_data  (rxcnt_data),
		.mirror_data (mirror_data),
		.data_in     (data_in)
	);

	// Configuration byte out to the board enables
	assign cfg_d02              = misc_config.cfg_d02;
	assign mmc_int              = misc_config.mmc_int;
	assign allow_mmc_eth_config = misc_config.allow_mmc_eth_config;
	assign zest_pwr_en          = misc_config.zest_pwr_en;
	assign ext_config           = misc_config.ext_config;

endmodule

`default_nettype wire

// ==== design/lb_read_mux.sv ====
// Second read cycle: registered address decode and read data register
`timescale 1ns/100ps
`default_nettype none

`include "marble_cfg.svh"

module lb_read_mux (
	input  wire                          clk,
	input  wire                          rst_n,
	lb_if.slave                          bus,
	input  wire marble_lb_pkg::lb_word_t status_data,
	input  wire marble_lb_pkg::rx_count_t rxcnt_data,
	input  wire marble_lb_pkg::lb_word_t mirror_data,
	output marble_lb_pkg::lb_word_t      data_in
);
	import marble_lb_pkg::*;

	lb_addr_t addr_r;
	lb_page_t page_r;
	logic     rd_r;
	lb_word_t rd_word;

	// Address and strobe of the read launched one cycle ago
	always_ff @(posedge clk) begin
		if (!rst_n)
			rd_r <= 1'b0;
		else
			rd_r <= bus.strobe & bus.rd;
	end

	always_ff @(posedge clk) begin
		addr_r <= bus.addr;
	end

	assign page_r = addr_r[`LB_AW-1 -: 8];

	// --------------------
	// Page decode
	// --------------------
	always_comb begin
		if (page_r == `LB_PAGE_STATUS && !addr_r[11] && !addr_r[4])
			rd_word = status_data;
		else if (addr_r[`LB_AW-1 -: 12] == `LB_PAGE_RXCNT)
			rd_word = {{(`LB_DW-`RXCNT_DW){1'b0}}, rxcnt_data};
		else if (page_r == `LB_PAGE_LOCAL)
			rd_word = mirror_data;
		else
			rd_word = `LB_DEFAULT_DATA;
	end

	// Holds the last result until the next read lands
	always_ff @(posedge clk) begin
		if (!rst_n)
			data_in <= '0;
		else if (rd_r)
			data_in <= rd_word;
	end

endmodule

`default_nettype wire

// ==== design/rx_counter.sv ====
// Received-packet category counters with update copy and host read copy
`timescale 1ns/100ps
`default_nettype none

`include "marble_cfg.svh"

module rx_counter (
	input  wire                      clk,
	input  wire                      rst_n,
	lb_if.slave                      bus,
	input  wire                      rx_category_s,
	input  wire [`RXCNT_AW-1:0]      rx_category,
	output marble_lb_pkg::rx_count_t rxcnt_data
);
	import marble_lb_pkg::*;

	logic [`RXCNT_AW-1:0] cat_r;
	logic [`RXCNT_AW-1:0] cat_rr;
	logic [`RXCNT_AW-1:0] clr_ptr;
	logic [`RXCNT_AW-1:0] wr_addr;
	logic                 inc_r;
	logic                 inc_rr;
	logic                 clr_active;
	logic                 wr_en;
	rx_count_t            upd_rdata;
	rx_count_t            wr_data;

	// --------------------
	// Update pipeline
	// --------------------
	// Sample pulse, read the old count, then write back count plus one
	// Clearing sweep starts in reset and finishes the last entries just after it
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			inc_r <= 1'b0;
			inc_rr <= 1'b0;
			clr_active <= 1'b1;
			if (clr_active)
				clr_ptr <= clr_ptr + 1'b1;
			else
				clr_ptr <= '0;
		end else begin
			inc_r <= rx_category_s;
			inc_rr <= inc_r;
			if (clr_active) begin
				clr_ptr <= clr_ptr + 1'b1;
				if (&clr_ptr)
					clr_active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		cat_r <= rx_category;
		cat_rr <= cat_r;
	end

	assign wr_en   = clr_active | inc_rr;
	assign wr_addr = clr_active ? clr_ptr : cat_rr;
	assign wr_data = clr_active ? '0 : upd_rdata + rx_count_t'(1);

	// Read-modify-write copy
	lb_dpram #(.payload_t(rx_count_t), .AW(`RXCNT_AW)) upd_mem_i (
		.clk   (clk),
		.we    (wr_en),
		.waddr (wr_addr),
		.wdata (wr_data),
		.raddr (cat_r),
		.rdata (upd_rdata)
	);

	// Same writes, read port left to the host
	lb_dpram #(.payload_t(rx_count_t), .AW(`RXCNT_AW)) host_mem_i (
		.clk   (clk),
		.we    (wr_en),
		.waddr (wr_addr),
		.wdata (wr_data),
		.raddr (bus.addr[`RXCNT_AW-1:0]),
		.rdata (rxcnt_data)
	);

endmodule

`default_nettype wire

// ==== design/led_pwm.sv ====
// LED cycle counter, uptime tick and duty-factor PWM outputs
`timescale 1ns/100ps
`default_nettype none

`include "marble_cfg.svh"

module led_pwm (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire marble_lb_pkg::duty_t led1_duty,
	input  wire marble_lb_pkg::duty_t led2_duty,
	output logic                      led1,
	output logic                      led2,
	output logic                      uptime_tick
);

	logic [`LED_CW-1:0] led_cc;
	// Duty times four, so a full byte covers the whole period
	logic [`LED_CW-1:0] led1_thr;
	logic [`LED_CW-1:0] led2_thr;

	assign led1_thr = {led1_duty, 2'b00};
	assign led2_thr = {led2_duty, 2'b00};

	// Blink rate is far above what the eye can see
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			led_cc <= '0;
			uptime_tick <= 1'b0;
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led_cc <= led_cc + 1'b1;
			// Pulse once per wrap of the cycle counter
			uptime_tick <= &led_cc;
			led1 <= led_cc < led1_thr;
			led2 <= led_cc < led2_thr;
		end
	end

endmodule

`default_nettype wire

// ==== design/ctrl_regs.sv ====
// Local write decode and direct-write control registers
`timescale 1ns/100ps
`default_nettype none

`include "marble_cfg.svh"

module ctrl_regs (
	input  wire                         clk,
	input  wire                         rst_n,
	lb_if.slave                         bus,
	output logic                        local_wr,
	output logic [1:0]                  led_user_mode,
	output marble_lb_pkg::duty_t        led1_duty,
	output marble_lb_pkg::duty_t        led2_duty,
	output marble_lb_pkg::misc_config_t misc_config
);
	import marble_lb_pkg::*;

	lb_page_t page;

	assign page = bus.addr[`LB_AW-1 -: 8];

	// Any write to the local page, also feeds the mirror memory
	assign local_wr = bus.strobe & ~bus.rd & (page == `LB_PAGE_LOCAL);

	// --------------------
	// Direct writes
	// --------------------
	// Offsets not listed here only land in the mirror
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			led_user_mode <= 2'b00;
			led1_duty <= '0;
			led2_duty <= '0;
			misc_config <= misc_config_t'(`MISC_CONFIG_DEFAULT);
		end else if (local_wr) begin
			case (bus.addr[4:0])
				5'd1: led_user_mode <= bus.wdata[1:0];
				5'd2: led1_duty <= bus.wdata[7:0];
				5'd3: led2_duty <= bus.wdata[7:0];
				// Board enables, split apart at the top level
				5'd8: misc_config <= misc_config_t'(bus.wdata[7:0]);
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/status_bank.sv ====
// Status bank: ID words, fault counter, uptime, MAC status sync and first read stage
`timescale 1ns/100ps
`default_nettype none

module status_bank (
	input  wire                     clk,
	input  wire                     rst_n,
	lb_if.slave                     bus,
	input  wire                     xdomain_fault,
	input  wire                     tx_mac_done,
	input  wire [1:0]               rx_mac_buf_status,
	input  wire                     uptime_tick,
	output marble_lb_pkg::lb_word_t status_data
);
	import marble_lb_pkg::*;

	// Spells "Hello world!(::)" across offsets 0 to 3
	localparam lb_word_t id_word_0 = "Hell";
	localparam lb_word_t id_word_1 = "o wo";
	localparam lb_word_t id_word_2 = "rld!";
	localparam lb_word_t id_word_3 = "(::)";

	logic [15:0] fault_count;
	logic [31:0] uptime;
	logic        tx_done_r;
	logic [1:0]  rx_status_r;
	logic        do_rd;

	assign do_rd = bus.strobe & bus.rd;

	// --------------------
	// Counters and status sync
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fault_count <= '0;
			uptime <= '0;
			tx_done_r <= 1'b0;
			rx_status_r <= '0;
		end else begin
			// A burst at startup is expected while the clock trees settle
			if (xdomain_fault)
				fault_count <= fault_count + 16'd1;
			// One tick per LED period
			if (uptime_tick)
				uptime <= uptime + 32'd1;
			// MAC levels come from another block, register them in clk
			tx_done_r <= tx_mac_done;
			rx_status_r <= rx_mac_buf_status;
		end
	end

	// --------------------
	// First read cycle
	// --------------------
	always_ff @(posedge clk) begin
		if (do_rd) begin
			case (bus.addr[3:0])
				4'h0: status_data <= id_word_0;
				4'h1: status_data <= id_word_1;
				4'h2: status_data <= id_word_2;
				4'h3: status_data <= id_word_3;
				4'h4: status_data <= {16'd0, fault_count};
				4'h5: status_data <= uptime;
				4'h6: status_data <= {31'd0, tx_done_r};
				4'h7: status_data <= {30'd0, rx_status_r};
				default: status_data <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/lb_dpram.sv ====
// Simple dual-port memory with registered read and a type-parameterized payload
`timescale 1ns/100ps
`default_nettype none

module lb_dpram #(
	parameter type payload_t = marble_lb_pkg::lb_word_t,
	parameter int  AW        = 5
) (
	input  wire           clk,
	input  wire           we,
	input  wire [AW-1:0]  waddr,
	input  wire payload_t wdata,
	input  wire [AW-1:0]  raddr,
	output payload_t      rdata
);

	payload_t mem [0:(1<<AW)-1];

	// Write port
	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Read port, one cycle latency
	// A write at the previous edge is already visible here
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// ==== design/lb_if.sv ====
// Internal local bus interface with master and slave modports
`timescale 1ns/100ps
`default_nettype none

interface lb_if;
	import marble_lb_pkg::*;

	lb_addr_t addr;
	logic     strobe;
	// High for a read, low for a write
	logic     rd;
	lb_word_t wdata;

	// Driven from the top level bus pins
	modport master (
		output addr,
		output strobe,
		output rd,
		output wdata
	);

	// Every register peer and the read mux
	modport slave (
		input addr,
		input strobe,
		input rd,
		input wdata
	);

endinterface

`default_nettype wire

// ==== design/marble_lb_pkg.sv ====
// Types for the local bus, data words, packet counts and control registers
`default_nettype none

package marble_lb_pkg;

	`include "marble_cfg.svh"

	// Bus address and data
	typedef logic [`LB_AW-1:0] lb_addr_t;
	typedef logic [`LB_DW-1:0] lb_word_t;

	// Upper address byte, used by the page decoders
	typedef logic [7:0] lb_page_t;

	// One entry of the packet counter bank
	typedef logic [`RXCNT_DW-1:0] rx_count_t;

	// LED brightness, scaled by four against the LED cycle counter
	typedef logic [7:0] duty_t;

	// --------------------
	// Board configuration byte
	// --------------------
	// Bit 0 is cfg_d02, bits 7:4 are ext_config
	typedef struct packed {
		logic [3:0] ext_config;
		logic       zest_pwr_en;
		logic       allow_mmc_eth_config;
		logic       mmc_int;
		logic       cfg_d02;
	} misc_config_t;

endpackage

`default_nettype wire

// ==== include/marble_cfg.svh ====
// Local bus widths, page decode values, counter widths and configuration default
`ifndef MARBLE_CFG_SVH
`define MARBLE_CFG_SVH

// --------------------
// Local bus
// --------------------
`define LB_AW 24
`define LB_DW 32

// Upper address byte for the read-only status bank
`define LB_PAGE_STATUS 8'h00
// Direct writes and their mirror readback
`define LB_PAGE_LOCAL 8'h05
// Upper 12 address bits for counter reads: page 4 with bit 12 set
`define LB_PAGE_RXCNT 12'h041

// Returned for any address nobody claims
`define LB_DEFAULT_DATA 32'hdeadbeef

// --------------------
// Storage and counters
// --------------------
`define MIRROR_AW 5
`define RXCNT_AW 4
`define RXCNT_DW 20

// 10 bits gives one LED period per 1024 clocks
`define LED_CW 10

`define MISC_CONFIG_DEFAULT 8'h00

`endif
